// ==== hw/board_pkg.sv ====
// board package
// shared types for the serial echo subsystem: payload and LED words,
// the received frame, and the state encodings of the UART and handshake FSMs

package board_pkg;

  // one serial payload byte
  typedef logic [7:0] data_byte_t;

  // LED word, bit 7 is the frame error toggle
  typedef logic [7:0] led_bits_t;

  // frame as offered by the receiver on link A
  typedef struct packed {
    data_byte_t payload;
    logic       frame_err;  // stop bit sampled low
  } rx_frame_t;

  // four-phase sender side
  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,
    HS_WAIT_DROP
  } hs_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

// ==== hw/reset_stretch.sv ====
// reset stretcher
// keeps the core in reset for a fixed number of cycles after the
// board reset is released

`timescale 1ns/1ps

module reset_stretch (
  input  logic clk_25mhz,
  input  logic rst_n,
  output logic core_rst_n
);

  localparam int RESET_CYCLES = 16;

  logic [RESET_CYCLES-1:0] hold_sr;

  // ones shift out towards bit 0, zeros come in from the top
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      hold_sr <= '1;
    end else begin
      hold_sr <= hold_sr >> 1;
    end
  end

  assign core_rst_n = ~hold_sr[0];

  // a low board reset must reach the core on the very next cycle
  core_rst_follows: assert property (@(posedge clk_25mhz)
    !rst_n |=> !core_rst_n);

endmodule

// ==== hw/uart_rx.sv ====
// UART receiver
// synchronizes the serial line, deframes 8N1 frames sampled at mid-bit
// and offers each frame on link A with a four-phase request

`timescale 1ns/1ps

module uart_rx import board_pkg::*; #(
  parameter int CLKS_PER_BIT = 217
) (
  input  logic      clk_25mhz,
  input  logic      rst_n,
  input  logic      rx,
  output logic      rx_req,
  input  logic      rx_ack,
  output rx_frame_t rx_frame
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [CNT_W-1:0] CNT_END = CNT_W'(CLKS_PER_BIT - 1);

  logic             rx_meta;
  logic             rx_sync;
  rx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  data_byte_t       shreg;
  logic             frame_done;
  hs_state_t        hs_state;
  logic             sample_bit;
  logic             accept_frame;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign sample_bit = (state == RX_DATA) && (cnt == CNT_END);
  // frame dropped when the previous one is still in the handshake
  assign accept_frame = (state == RX_STOP) && (cnt == CNT_END) && (hs_state == HS_IDLE);

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      state      <= RX_IDLE;
      cnt        <= '0;
      bit_idx    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= accept_frame;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // glitch filter: start must still be low at mid-bit
          if (cnt == CNT_MID) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt == CNT_END) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (cnt == CNT_END) begin
            cnt   <= '0;
            state <= RX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // payload path, LSB first
  always_ff @(posedge clk_25mhz) begin
    if (sample_bit) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
    if (accept_frame) begin
      rx_frame.payload   <= shreg;
      rx_frame.frame_err <= ~rx_sync;
    end
  end

  // link A sender
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      hs_state <= HS_IDLE;
    end else begin
      case (hs_state)
        HS_IDLE:      if (frame_done) hs_state <= HS_REQ;
        HS_REQ:       if (rx_ack) hs_state <= HS_WAIT_DROP;
        HS_WAIT_DROP: if (!rx_ack) hs_state <= HS_IDLE;
        default:      hs_state <= HS_IDLE;
      endcase
    end
  end

  assign rx_req = (hs_state == HS_REQ);

  rx_frame_hold: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    rx_req |=> !rx_req || $stable(rx_frame));

endmodule

// ==== hw/echo_core.sv ====
// echo core
// takes frames from the receiver, swaps the case of ASCII letters,
// hands good bytes to the transmitter and keeps the LED state

`timescale 1ns/1ps

module echo_core import board_pkg::*; (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  input  logic       rx_req,
  output logic       rx_ack,
  input  rx_frame_t  rx_frame,
  output logic       tx_req,
  input  logic       tx_ack,
  output data_byte_t tx_byte,
  output led_bits_t  leds
);

  hs_state_t tx_hs;
  logic      accept;

  function automatic data_byte_t toggle_case(input data_byte_t b);
    logic is_upper;
    logic is_lower;
    is_upper = (b >= 8'h41) && (b <= 8'h5a);
    is_lower = (b >= 8'h61) && (b <= 8'h7a);
    return (is_upper || is_lower) ? (b ^ 8'h20) : b;
  endfunction

  // only take a frame when link B has nothing pending
  assign accept = rx_req && !rx_ack && (tx_hs == HS_IDLE);

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      rx_ack <= 1'b0;
      tx_hs  <= HS_IDLE;
      leds   <= '0;
    end else begin
      // link A receiver side
      if (accept) begin
        rx_ack <= 1'b1;
      end else if (rx_ack && !rx_req) begin
        rx_ack <= 1'b0;
      end

      // link B sender, request goes up together with rx_ack
      case (tx_hs)
        HS_IDLE:      if (accept && !rx_frame.frame_err) tx_hs <= HS_REQ;
        HS_REQ:       if (tx_ack) tx_hs <= HS_WAIT_DROP;
        HS_WAIT_DROP: if (!tx_ack) tx_hs <= HS_IDLE;
        default:      tx_hs <= HS_IDLE;
      endcase

      if (accept) begin
        if (rx_frame.frame_err) begin
          leds[7] <= ~leds[7];
        end else begin
          leds[6:0] <= rx_frame.payload[6:0];
        end
      end
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (accept && !rx_frame.frame_err) begin
      tx_byte <= toggle_case(rx_frame.payload);
    end
  end

  assign tx_req = (tx_hs == HS_REQ);

  // four-phase rules on link B
  tx_req_after_ack_low: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    $rose(tx_req) |-> !tx_ack);

  tx_byte_hold: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
    tx_req |=> !tx_req || $stable(tx_byte));

endmodule

// ==== hw/uart_tx.sv ====
// UART transmitter
// accepts a byte on link B and shifts out one 8N1 frame,
// line idles high between frames

`timescale 1ns/1ps

module uart_tx import board_pkg::*; #(
  parameter int CLKS_PER_BIT = 217
) (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  input  logic       tx_req,
  output logic       tx_ack,
  input  data_byte_t tx_byte,
  output logic       tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_END = CNT_W'(CLKS_PER_BIT - 1);

  tx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  data_byte_t       shreg;
  logic             start_frame;
  logic             bit_end;

  // new request only between frames and after the old ack has dropped
  assign start_frame = (state == TX_IDLE) && tx_req && !tx_ack;
  assign bit_end     = (cnt == CNT_END);

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_ack  <= 1'b0;
      tx      <= 1'b1;
    end else begin
      if (start_frame) begin
        tx_ack <= 1'b1;
      end else if (tx_ack && !tx_req) begin
        tx_ack <= 1'b0;
      end

      case (state)
        TX_IDLE: begin
          tx      <= 1'b1;
          cnt     <= '0;
          bit_idx <= '0;
          if (start_frame) begin
            state <= TX_START;
          end
        end
        TX_START: begin
          tx <= 1'b0;
          if (bit_end) begin
            cnt   <= '0;
            state <= TX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        TX_DATA: begin
          tx <= shreg[0];
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        TX_STOP: begin
          tx <= 1'b1;
          if (bit_end) begin
            cnt   <= '0;
            state <= TX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // byte latched on accept, LSB leaves first
  always_ff @(posedge clk_25mhz) begin
    if (start_frame) begin
      shreg <= tx_byte;
    end else if ((state == TX_DATA) && bit_end) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

// ==== hw/board_top.sv ====
// board top level
// serial echo subsystem: reset stretcher, UART receiver, case-swapping
// core and UART transmitter, with the last good byte shown on the LEDs

`timescale 1ns/1ps

module board_top import board_pkg::*; #(
  parameter int CLKS_PER_BIT = 217
) (
  input  logic      clk_25mhz,
  input  logic      rst_n,
  input  logic      rx,
  output logic      tx,
  output led_bits_t leds
);

  logic       core_rst_n;
  // link A
  logic       rx_req;
  logic       rx_ack;
  rx_frame_t  rx_frame;
  // link B
  logic       tx_req;
  logic       tx_ack;
  data_byte_t tx_byte;

  reset_stretch reset_stretch_inst (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .core_rst_n(core_rst_n)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
    .clk_25mhz(clk_25mhz),
    .rst_n    (core_rst_n),
    .rx       (rx),
    .rx_req   (rx_req),
    .rx_ack   (rx_ack),
    .rx_frame (rx_frame)
  );

  echo_core echo_core_inst (
    .clk_25mhz(clk_25mhz),
    .rst_n    (core_rst_n),
    .rx_req   (rx_req),
    .rx_ack   (rx_ack),
    .rx_frame (rx_frame),
    .tx_req   (tx_req),
    .tx_ack   (tx_ack),
    .tx_byte  (tx_byte),
    .leds     (leds)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
    .clk_25mhz(clk_25mhz),
    .rst_n    (core_rst_n),
    .tx_req   (tx_req),
    .tx_ack   (tx_ack),
    .tx_byte  (tx_byte),
    .tx       (tx)
  );

endmodule

// ==== verification/board_top_tb.sv ====
// testbench for the serial echo board
// drives 8N1 frames into rx, decodes the echo on tx and checks the
// case-swap rule, the LED state and the reset stretch

`timescale 1ns/1ps

module board_top_tb import board_pkg::*; ();

  localparam int CLKS_PER_BIT   = 8;
  localparam int STRETCH_WAIT   = 20;
  localparam int RANDOM_FRAMES  = 40;
  // frames per test: 2, 4, 7, 2, random run, 2
  localparam int FRAMES_SENT    = 2 + 4 + 7 + 2 + RANDOM_FRAMES + 2;
  localparam int TIMEOUT_CYCLES = FRAMES_SENT * 10 * CLKS_PER_BIT * 3 + 500;

  logic       clk_25mhz;
  logic       rst_n;
  logic       rx;
  logic       tx;
  led_bits_t  leds;

  data_byte_t src_q[$];
  data_byte_t exp_q[$];
  data_byte_t rcv_q[$];

  int          error_count  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycle_count  = 0;
  int          echo_count   = 0;
  bit          mon_busy     = 1'b0;
  logic        led7_ref;
  led_bits_t   led_ref      = '0;
  logic [16:0] hist         = '0;
  logic [31:0] rng_state    = 32'd71;

  board_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) board_top_inst (
    .clk_25mhz(clk_25mhz),
    .rst_n    (rst_n),
    .rx       (rx),
    .tx       (tx),
    .leds     (leds)
  );

  initial begin
    clk_25mhz = 1'b0;
    forever #20 clk_25mhz = ~clk_25mhz;
  end

  always @(posedge clk_25mhz) begin
    cycle_count <= cycle_count + 1;
    hist        <= {hist[15:0], ~rst_n};
  end

  // LED word expected while the next echo starts
  always @(posedge clk_25mhz) begin
    if (echo_count < src_q.size()) begin
      led_ref <= {led7_ref, src_q[echo_count][6:0]};
    end else begin
      led_ref <= {led7_ref, 7'h00};
    end
  end

  // a low rst_n two to seventeen edges back keeps the outputs at reset values
  reset_holds_outputs: assert property (@(posedge clk_25mhz)
    (|hist[16:1]) |-> (tx === 1'b1) && (leds === 8'h00))
    else begin
      $display("[ERROR] %0t: tx or leds not at reset value during reset stretch", $time);
      error_count++;
    end

  leds_show_last_byte: assert property (@(posedge clk_25mhz)
    $fell(tx) && (hist == '0) |-> leds === led_ref)
    else begin
      $display("[ERROR] %0t: leds 0x%02h at echo start, expected 0x%02h",
               $time, leds, led_ref);
      error_count++;
    end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // ASCII letters swap case, everything else is echoed as it is
  function automatic data_byte_t swap_case(input data_byte_t b);
    if (b >= "A" && b <= "Z") begin
      return b + 8'd32;
    end
    if (b >= "a" && b <= "z") begin
      return b - 8'd32;
    end
    return b;
  endfunction

  task automatic drive_bit(input logic value);
    @(posedge clk_25mhz);
    rx <= value;
    repeat (CLKS_PER_BIT - 1) @(posedge clk_25mhz);
  endtask

  // start, eight data bits LSB first, stop, then one idle bit
  task automatic send_frame(input data_byte_t b, input logic stop_ok);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(stop_ok);
    drive_bit(1'b1);
  endtask

  task automatic send_byte(input data_byte_t b, input bit expect_echo);
    src_q.push_back(b);
    if (expect_echo) begin
      exp_q.push_back(swap_case(b));
    end
    send_frame(b, 1'b1);
  endtask

  task automatic hold_reset();
    rst_n    <= 1'b0;
    led7_ref <= 1'b0;
    repeat (3) @(posedge clk_25mhz);
    rst_n <= 1'b1;
  endtask

  task automatic compare_echoes();
    data_byte_t want;
    data_byte_t got;
    while (rcv_q.size() < exp_q.size()) @(posedge clk_25mhz);
    while (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      got  = rcv_q.pop_front();
      echo_matches: assert (got === want)
        else begin
          $display("[ERROR] %0t: echo 0x%02h, expected 0x%02h", $time, got, want);
          error_count++;
        end
    end
    if (rcv_q.size() != 0) begin
      $display("[ERROR] %0t: %0d echoes arrived that were never sent", $time, rcv_q.size());
      error_count++;
      rcv_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic follow_tx_cycles(input int cycles, inout bit aborted);
    repeat (cycles) begin
      @(negedge clk_25mhz);
      if (rst_n !== 1'b1) begin
        aborted = 1'b1;
      end
    end
  endtask

  // tx decoder, frames cut by a reset are counted but not kept
  initial begin : tx_monitor
    data_byte_t got;
    logic       stop_bit;
    bit         aborted;
    forever begin
      @(negedge clk_25mhz);
      if (tx === 1'b0 && rst_n === 1'b1) begin
        mon_busy = 1'b1;
        aborted  = 1'b0;
        // half a cycle in already, move on to mid start bit
        follow_tx_cycles(CLKS_PER_BIT / 2 - 1, aborted);
        for (int i = 0; i < 8; i++) begin
          follow_tx_cycles(CLKS_PER_BIT, aborted);
          got[i] = tx;
        end
        follow_tx_cycles(CLKS_PER_BIT, aborted);
        stop_bit = tx;
        echo_count++;
        mon_busy = 1'b0;
        if (!aborted && stop_bit === 1'b1) begin
          rcv_q.push_back(got);
        end else if (!aborted) begin
          $display("[ERROR] %0t: stop bit on tx is not high", $time);
          error_count++;
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) @(posedge clk_25mhz);
    $display("run stopped after %0d cycles before all tests had finished", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin : tests
    int          errs;
    int          echoes_before;
    led_bits_t   led_before;
    logic [31:0] rnd;
    rx <= 1'b1;
    hold_reset();

    // frame starting at release, start bit and bit 0 fall inside the stretch
    // so the all-ones remainder must not be taken as a frame
    errs = error_count;
    send_frame(8'hff, 1'b1);
    send_byte("k", 1'b1);
    compare_echoes();
    report_test("reset stretch and first echo", errs);

    errs = error_count;
    send_byte("a", 1'b1);
    send_byte("Z", 1'b1);
    send_byte("m", 1'b1);
    send_byte("Q", 1'b1);
    compare_echoes();
    report_test("letter case swap", errs);

    errs = error_count;
    send_byte("0", 1'b1);
    send_byte("5", 1'b1);
    send_byte("9", 1'b1);
    send_byte("@", 1'b1);
    send_byte("[", 1'b1);
    send_byte(8'h00, 1'b1);
    send_byte(8'hff, 1'b1);
    compare_echoes();
    report_test("non-letters unchanged", errs);

    errs = error_count;
    @(negedge clk_25mhz);
    led_before    = leds;
    echoes_before = echo_count;
    send_frame(8'h4e, 1'b0);
    repeat (2 * CLKS_PER_BIT) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    no_echo_on_error: assert (echo_count == echoes_before && !mon_busy)
      else begin
        $display("[ERROR] %0t: frame with low stop bit was echoed", $time);
        error_count++;
      end
    led7_toggles: assert (leds === {~led_before[7], led_before[6:0]})
      else begin
        $display("[ERROR] %0t: leds 0x%02h after frame error, expected 0x%02h",
                 $time, leds, {~led_before[7], led_before[6:0]});
        error_count++;
      end
    led7_ref <= ~led7_ref;
    send_byte("x", 1'b1);
    compare_echoes();
    report_test("frame error", errs);

    errs = error_count;
    for (int n = 0; n < RANDOM_FRAMES; n++) begin
      rnd = next_random();
      send_byte(rnd[7:0], 1'b1);
    end
    compare_echoes();
    report_test("random back to back", errs);

    // echo of the first byte is cut short by the reset
    errs = error_count;
    send_byte("r", 1'b0);
    while (!mon_busy) @(posedge clk_25mhz);
    repeat (4 * CLKS_PER_BIT) @(posedge clk_25mhz);
    hold_reset();
    repeat (STRETCH_WAIT) @(posedge clk_25mhz);
    send_byte("G", 1'b1);
    compare_echoes();
    report_test("reset in mid frame", errs);

    $display("summary: %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== board_top.f ====
hw/board_pkg.sv
hw/reset_stretch.sv
hw/uart_rx.sv
hw/echo_core.sv
hw/uart_tx.sv
hw/board_top.sv
verification/board_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the board_top testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=board_top_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module board_top_tb \
  -f board_top.f \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG_FILE"; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation passed"
exit 0
